//--- flist.f
+incdir+hdl
hdl/xbus_pkg.sv
hdl/xbus_ram.sv
hdl/sdram_ctl.sv
hdl/xbus_io.sv
hdl/xbus_mux.sv
hdl/xbus_top.sv
test/xbus_tb.sv

//--- test/xbus_tb.sv
// Testbench for the bus top level with random accesses, reference model, checks and watchdog

`timescale 1ns/100ps

`include "xbus_settings.svh"

module xbus_tb;

   import xbus_pkg::*;

   localparam int          CLK_HALF     = 20;
   localparam int          RESET_CYCLES = 16;
   localparam int          N_ACCESS     = 400;
   localparam int          MAX_WAIT     = `XBUS_TIMEOUT + 4;
   localparam logic [31:0] SEED         = 32'hf294_2cc5;
   localparam int unsigned RAM_LIMIT    = `XBUS_RAM_LIMIT;
   localparam int unsigned RAM_PAGES    = RAM_LIMIT / `SDRAM_WORDS;
   localparam int unsigned IO_BASE      = {`XBUS_IO_PAGE, 5'b00000};

   logic                   clk;
   logic                   reset;
   logic [XBUS_ADDR_W-1:0] addr;
   logic [XBUS_DATA_W-1:0] datain;
   logic                   req;
   logic                   write;
   logic [XBUS_DATA_W-1:0] dataout;
   logic                   ack;
   logic                   nxm;

   // Reference model state
   logic [XBUS_DATA_W-1:0] mem_model [0:`SDRAM_WORDS-1];
   bit                     written_flag [0:`SDRAM_WORDS-1];
   int unsigned            written_q [$];
   logic [XBUS_DATA_W-1:0] scratch_model [0:7];
   int unsigned            ack_count;

   logic [31:0]            lcg_state;
   int                     checks;
   int                     data_errors;
   int                     timing_errors;
   int                     protocol_errors;

   xbus_top i_xbus_top (
      .clk     (clk),
      .reset   (reset),
      .addr    (addr),
      .datain  (datain),
      .req     (req),
      .write   (write),
      .dataout (dataout),
      .ack     (ack),
      .nxm     (nxm)
   );

   always #(CLK_HALF) clk = ~clk;

   // Upper bits of the LCG state, the low bits cycle too quickly
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {8'h00, lcg_state[31:8]};
   endfunction

   // One bus access, entered right after a rising edge
   task automatic run_access(
      input logic [XBUS_ADDR_W-1:0] a,
      input logic                   w,
      input logic [XBUS_DATA_W-1:0] d,
      input int                     exp_latency,
      input logic                   exp_nxm,
      input logic                   check_data,
      input logic [XBUS_DATA_W-1:0] exp_data
   );
      int                     cycles;
      logic                   got_ack;
      logic                   seen_nxm;
      logic [XBUS_DATA_W-1:0] seen_data;

      addr    <= a;
      datain  <= d;
      write   <= w;
      req     <= 1'b1;
      cycles   = 0;
      got_ack  = 1'b0;
      seen_nxm = 1'b0;
      seen_data = '0;
      while (!got_ack && cycles <= MAX_WAIT) begin
         @(negedge clk);
         if (ack) begin
            got_ack   = 1'b1;
            seen_nxm  = nxm;
            seen_data = dataout;
         end else begin
            @(posedge clk);
            cycles++;
         end
      end

      checks++;
      assert (got_ack) else begin
         protocol_errors++;
         $display("Access to address %o got no ack within %0d cycles", a, MAX_WAIT);
      end

      if (got_ack) begin
         ack_count++;
         checks += 2;
         assert (cycles == exp_latency) else begin
            timing_errors++;
            $display("ERROR at %0t: ack for address %o after %0d cycles, expected %0d",
                     $time, a, cycles, exp_latency);
         end
         assert (seen_nxm == exp_nxm) else begin
            data_errors++;
            $display("ERROR at %0t: nxm is %b for address %o, expected %b",
                     $time, seen_nxm, a, exp_nxm);
         end
         if (check_data) begin
            checks++;
            assert (seen_data == exp_data) else begin
               data_errors++;
               $display("ERROR at %0t: read of address %o returned %h, expected %h",
                        $time, a, seen_data, exp_data);
            end
         end
      end

      // Release the bus in the cycle after ack
      @(posedge clk);
      req <= 1'b0;
   endtask

   task automatic wait_idle();
      int n;

      n = 1 + next_rand() % 3;
      repeat (n) @(posedge clk);
   endtask

   // Pick a region, address, direction and data, then run and update the model
   task automatic run_random_access();
      int unsigned            region;
      int unsigned            idx;
      int unsigned            reg_sel;
      logic [31:0]            r;
      logic                   w;
      logic [XBUS_DATA_W-1:0] d;
      logic [XBUS_ADDR_W-1:0] a;
      logic [XBUS_DATA_W-1:0] expect_data;
      xbus_addr_u             io_a;

      region = next_rand() % 8;
      r      = next_rand();
      w      = r[0];
      r      = next_rand();
      d[31:16] = r[15:0];
      r      = next_rand();
      d[15:0]  = r[15:0];

      if (region < 4) begin
         // Nothing to read back yet
         if (!w && written_q.size() == 0)
            w = 1'b1;
         if (w)
            idx = next_rand() % `SDRAM_WORDS;
         else
            idx = written_q[next_rand() % written_q.size()];
         // Random upper bits exercise the aliasing of the storage index
         a = XBUS_ADDR_W'((next_rand() % RAM_PAGES) * `SDRAM_WORDS + idx);
         run_access(a, w, d, `SDRAM_LATENCY, 1'b0, !w, mem_model[idx]);
         if (w) begin
            if (!written_flag[idx])
               written_q.push_back(idx);
            written_flag[idx] = 1'b1;
            mem_model[idx]    = d;
         end
      end else if (region < 6) begin
         r = next_rand();
         // Lean on the counter register so it gets read often
         if (r % 4 == 0)
            reg_sel = 8;
         else
            reg_sel = (r >> 2) % 32;
         io_a.io.io_page = `XBUS_IO_PAGE;
         io_a.io.io_reg  = reg_sel[4:0];
         if (reg_sel < 8)
            expect_data = scratch_model[reg_sel];
         else if (reg_sel == 8)
            expect_data = ack_count;
         else
            expect_data = '0;
         run_access(io_a.ram_word, w, d, 1, 1'b0, !w, expect_data);
         if (w && reg_sel < 8)
            scratch_model[reg_sel] = d;
      end else begin
         // Gap between the RAM region and the I/O page
         a = XBUS_ADDR_W'(RAM_LIMIT + next_rand() % (IO_BASE - RAM_LIMIT));
         run_access(a, w, d, `XBUS_TIMEOUT, 1'b1, 1'b1, {XBUS_DATA_W{1'b1}});
      end
   endtask

   // Bus-level rules that hold on every cycle
   always @(negedge clk) begin
      if (!reset) begin
         assert (req || !ack) else begin
            protocol_errors++;
            $display("ERROR at %0t: ack is high while req is low", $time);
         end
         assert (ack || !nxm) else begin
            protocol_errors++;
            $display("ERROR at %0t: nxm is high without ack", $time);
         end
      end
   end

   initial begin
      #((N_ACCESS * MAX_WAIT + RESET_CYCLES + 8) * 2 * CLK_HALF);
      $display("Run timed out before all %0d accesses completed", N_ACCESS);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      addr            = '0;
      datain          = '0;
      req             = 1'b0;
      write           = 1'b0;
      lcg_state       = SEED;
      ack_count       = 0;
      checks          = 0;
      data_errors     = 0;
      timing_errors   = 0;
      protocol_errors = 0;
      for (int i = 0; i < 8; i++)
         scratch_model[i] = '0;

      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);

      for (int n = 0; n < N_ACCESS; n++) begin
         run_random_access();
         wait_idle();
      end

      $display("Checks: %0d, data errors: %0d, timing errors: %0d, protocol errors: %0d",
               checks, data_errors, timing_errors, protocol_errors);
      if (data_errors + timing_errors + protocol_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- hdl/xbus_top.sv
// Top level tying the bus port to RAM, controller, I/O page and response mux

`timescale 1ns/100ps

module xbus_top (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [xbus_pkg::XBUS_ADDR_W-1:0] addr,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] datain,
   input  logic                           req,
   input  logic                           write,
   output logic [xbus_pkg::XBUS_DATA_W-1:0] dataout,
   output logic                           ack,
   output logic                           nxm
);

   import xbus_pkg::*;

   xbus_addr_u             io_addr;

   logic [XBUS_DATA_W-1:0] ram_dataout;
   logic                   ram_ack;
   logic                   ram_decode;
   logic [XBUS_DATA_W-1:0] io_dataout;
   logic                   io_ack;
   logic                   io_decode;

   // Controller link
   logic [XBUS_ADDR_W-1:0] sdram_addr;
   logic [XBUS_DATA_W-1:0] sdram_data_out;
   logic [XBUS_DATA_W-1:0] sdram_data_in;
   logic                   sdram_req;
   logic                   sdram_ready;
   logic                   sdram_write;
   logic                   sdram_done;

   // I/O block reads the same address as page and register
   assign io_addr = addr;

   xbus_ram i_xbus_ram (
      .clk            (clk),
      .reset          (reset),
      .addr           (addr),
      .datain         (datain),
      .req            (req),
      .write          (write),
      .dataout        (ram_dataout),
      .ack            (ram_ack),
      .decode         (ram_decode),
      .sdram_addr     (sdram_addr),
      .sdram_data_out (sdram_data_out),
      .sdram_data_in  (sdram_data_in),
      .sdram_req      (sdram_req),
      .sdram_ready    (sdram_ready),
      .sdram_write    (sdram_write),
      .sdram_done     (sdram_done)
   );

   sdram_ctl i_sdram_ctl (
      .clk            (clk),
      .reset          (reset),
      .sdram_addr     (sdram_addr),
      .sdram_data_out (sdram_data_out),
      .sdram_req      (sdram_req),
      .sdram_write    (sdram_write),
      .sdram_data_in  (sdram_data_in),
      .sdram_ready    (sdram_ready),
      .sdram_done     (sdram_done)
   );

   xbus_io i_xbus_io (
      .clk     (clk),
      .reset   (reset),
      .addr    (io_addr),
      .datain  (datain),
      .req     (req),
      .write   (write),
      .dataout (io_dataout),
      .ack     (io_ack),
      .decode  (io_decode),
      .bus_ack (ack)
   );

   xbus_mux i_xbus_mux (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .ram_decode  (ram_decode),
      .ram_ack     (ram_ack),
      .ram_dataout (ram_dataout),
      .io_decode   (io_decode),
      .io_ack      (io_ack),
      .io_dataout  (io_dataout),
      .dataout     (dataout),
      .ack         (ack),
      .nxm         (nxm)
   );

endmodule

//--- hdl/xbus_mux.sv
// Response mux with slave select and the no-slave timeout

`timescale 1ns/100ps

`include "xbus_settings.svh"

module xbus_mux (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           req,
   input  logic                           ram_decode,
   input  logic                           ram_ack,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] ram_dataout,
   input  logic                           io_decode,
   input  logic                           io_ack,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] io_dataout,
   output logic [xbus_pkg::XBUS_DATA_W-1:0] dataout,
   output logic                           ack,
   output logic                           nxm
);

   import xbus_pkg::*;

   localparam int TMO_W = $clog2(`XBUS_TIMEOUT);
   localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(`XBUS_TIMEOUT - 1);

   logic [TMO_W-1:0] tmo_cnt;
   logic             nxm_q;
   logic             unclaimed;

   assign unclaimed = req & ~ram_decode & ~io_decode;

   // Timeout runs only while nobody claims the request
   always_ff @(posedge clk) begin
      if (reset) begin
         tmo_cnt <= '0;
         nxm_q   <= 1'b0;
      end else if (unclaimed && !nxm_q) begin
         if (tmo_cnt == TMO_LAST) begin
            tmo_cnt <= '0;
            nxm_q   <= 1'b1;
         end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
         end
      end else begin
         tmo_cnt <= '0;
         nxm_q   <= 1'b0;
      end
   end

   assign nxm = nxm_q;

   always_comb begin
      if (ram_decode) begin
         ack     = ram_ack;
         dataout = ram_dataout;
      end else if (io_decode) begin
         ack     = io_ack;
         dataout = io_dataout;
      end else begin
         ack     = nxm_q;
         dataout = {XBUS_DATA_W{1'b1}};
      end
   end

   // RAM region and I/O page must not overlap
   a_decode_excl: assert property (
      @(posedge clk) disable iff (reset)
      !(ram_decode && io_decode)
   );

endmodule

//--- hdl/xbus_io.sv
// I/O register page with eight scratch registers and a bus-cycle counter

`timescale 1ns/100ps

`include "xbus_settings.svh"

module xbus_io (
   input  logic                           clk,
   input  logic                           reset,
   input  xbus_pkg::xbus_addr_u           addr,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] datain,
   input  logic                           req,
   input  logic                           write,
   output logic [xbus_pkg::XBUS_DATA_W-1:0] dataout,
   output logic                           ack,
   output logic                           decode,
   input  logic                           bus_ack
);

   import xbus_pkg::*;

   localparam logic [XBUS_IO_PAGE_W-1:0] IO_PAGE   = `XBUS_IO_PAGE;
   localparam logic [XBUS_IO_REG_W-1:0]  REG_COUNT = 5'd8;

   logic [XBUS_DATA_W-1:0] scratch [0:7];
   logic [XBUS_DATA_W-1:0] cycle_count;
   logic                   ack_q;
   logic                   accept;
   logic                   is_scratch;

   assign decode = (addr.io.io_page == IO_PAGE);

   // Registers 0 through 7 are the scratch bank
   assign is_scratch = (addr.io.io_reg < REG_COUNT);

   // Take the access once, the ack cycle masks a second accept
   assign accept = req & decode & ~ack_q;

   assign ack = ack_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++)
            scratch[i] <= '0;
      end else if (accept && write && is_scratch) begin
         scratch[addr.io.io_reg[2:0]] <= datain;
      end
   end

   // Counts every completed access, whichever slave answered
   always_ff @(posedge clk) begin
      if (reset)
         cycle_count <= '0;
      else if (bus_ack)
         cycle_count <= cycle_count + 1'b1;
   end

   // Count read during the ack cycle still excludes the current access
   always_comb begin
      if (is_scratch)
         dataout = scratch[addr.io.io_reg[2:0]];
      else if (addr.io.io_reg == REG_COUNT)
         dataout = cycle_count;
      else
         dataout = '0;
   end

   // Our ack must come out of the mux as the bus ack
   a_ack_forwarded: assert property (
      @(posedge clk) disable iff (reset)
      ack |-> bus_ack
   );

endmodule

//--- hdl/sdram_ctl.sv
// Fixed-latency memory controller over an internal storage array

`timescale 1ns/100ps

`include "xbus_settings.svh"

module sdram_ctl (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [xbus_pkg::XBUS_ADDR_W-1:0] sdram_addr,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] sdram_data_out,
   input  logic                           sdram_req,
   input  logic                           sdram_write,
   output logic [xbus_pkg::XBUS_DATA_W-1:0] sdram_data_in,
   output logic                           sdram_ready,
   output logic                           sdram_done
);

   import xbus_pkg::*;

   localparam int IDX_W = $clog2(`SDRAM_WORDS);
   localparam int CNT_W = $clog2(`SDRAM_LATENCY + 1);

   // Acceptance edge plus one edge to raise the pulse
   localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`SDRAM_LATENCY - 2);

   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_WAIT    = 2'd1;
   localparam logic [1:0] ST_RESPOND = 2'd2;
   localparam logic [1:0] ST_RELEASE = 2'd3;

   logic [1:0]             state;
   logic [CNT_W-1:0]       lat_cnt;
   logic [IDX_W-1:0]       addr_q;
   logic [XBUS_DATA_W-1:0] data_q;
   logic                   write_q;
   logic                   accept;
   logic                   commit;

   logic [XBUS_DATA_W-1:0] mem [0:`SDRAM_WORDS-1];

   assign accept = (state == ST_IDLE) & (sdram_req | sdram_write);
   assign commit = (state == ST_WAIT) & (lat_cnt == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= ST_IDLE;
         lat_cnt     <= '0;
         sdram_ready <= 1'b0;
         sdram_done  <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  lat_cnt <= CNT_LOAD;
                  state   <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (commit) begin
                  sdram_ready <= ~write_q;
                  sdram_done  <= write_q;
                  state       <= ST_RESPOND;
               end else begin
                  lat_cnt <= lat_cnt - 1'b1;
               end
            end
            ST_RESPOND: begin
               // Pulse lasts a single cycle
               sdram_ready <= 1'b0;
               sdram_done  <= 1'b0;
               state       <= ST_RELEASE;
            end
            default: begin
               // Hold off until the requester has let go
               if (!(sdram_req || sdram_write))
                  state <= ST_IDLE;
            end
         endcase
      end
   end

   // Access payload captured when the request is taken
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= sdram_addr[IDX_W-1:0];
         data_q  <= sdram_data_out;
         write_q <= sdram_write;
      end
   end

   // Storage port, written as done is raised
   always_ff @(posedge clk) begin
      if (commit && write_q)
         mem[addr_q] <= data_q;
      if (commit && !write_q)
         sdram_data_in <= mem[addr_q];
   end

   a_ready_has_req: assert property (
      @(posedge clk) disable iff (reset)
      sdram_ready |-> sdram_req
   );

   a_done_has_write: assert property (
      @(posedge clk) disable iff (reset)
      sdram_done |-> sdram_write
   );

endmodule

//--- hdl/xbus_ram.sv
// Bus interface to the memory controller with RAM region decode

`timescale 1ns/100ps

`include "xbus_settings.svh"

module xbus_ram (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [xbus_pkg::XBUS_ADDR_W-1:0] addr,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] datain,
   input  logic                           req,
   input  logic                           write,
   output logic [xbus_pkg::XBUS_DATA_W-1:0] dataout,
   output logic                           ack,
   output logic                           decode,
   output logic [xbus_pkg::XBUS_ADDR_W-1:0] sdram_addr,
   output logic [xbus_pkg::XBUS_DATA_W-1:0] sdram_data_out,
   input  logic [xbus_pkg::XBUS_DATA_W-1:0] sdram_data_in,
   output logic                           sdram_req,
   input  logic                           sdram_ready,
   output logic                           sdram_write,
   input  logic                           sdram_done
);

   import xbus_pkg::*;

   localparam logic [XBUS_ADDR_W-1:0] RAM_LIMIT = `XBUS_RAM_LIMIT;

   // Everything below the limit belongs to RAM
   assign decode = (addr < RAM_LIMIT);

   // Steer a claimed request to the read or the write line
   assign sdram_req   = req & decode & ~write;
   assign sdram_write = req & decode & write;

   // Address and write data go straight to the controller
   assign sdram_addr     = addr;
   assign sdram_data_out = datain;

   assign dataout = sdram_data_in;

   // Controller pulses only count while our request is still up
   assign ack = (sdram_write & sdram_done) | (sdram_req & sdram_ready);

   // Read and write lines are mutually exclusive
   a_req_write_excl: assert property (
      @(posedge clk) disable iff (reset)
      !(sdram_req && sdram_write)
   );

   // No ack edge without a live bus request
   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (reset)
      $rose(ack) |-> req
   );

endmodule

//--- hdl/xbus_pkg.sv
// Bus widths and the shared address union for the RAM and I/O views

package xbus_pkg;

   // Word address and data path widths
   localparam int XBUS_ADDR_W = 22;
   localparam int XBUS_DATA_W = 32;

   // I/O view of an address: page above, register index below
   localparam int XBUS_IO_PAGE_W = 17;
   localparam int XBUS_IO_REG_W  = 5;

   typedef struct packed {
      logic [XBUS_IO_PAGE_W-1:0] io_page;
      logic [XBUS_IO_REG_W-1:0]  io_reg;
   } xbus_io_addr_t;

   // One bus address word, read either as a RAM word or as page/register
   typedef union packed {
      logic [XBUS_ADDR_W-1:0] ram_word;
      xbus_io_addr_t          io;
   } xbus_addr_u;

endpackage

//--- hdl/xbus_settings.svh
// Memory depth, controller latency, bus timeout and region limit macros

`ifndef XBUS_SETTINGS_SVH
`define XBUS_SETTINGS_SVH

// First word address not claimed by the RAM region
`define XBUS_RAM_LIMIT 22'o11000000

// Page number of the I/O registers in the io_page field
// Places the register page at octal 17377740 through 17377777
`define XBUS_IO_PAGE 17'o367777

// Storage depth in words, RAM addresses alias modulo this depth
`define SDRAM_WORDS 4096

// Cycles from first request to ready or done, must be 2 or more
`define SDRAM_LATENCY 3

// Cycles an unclaimed request waits before the mux answers it
`define XBUS_TIMEOUT 16

`endif
